/* src/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // Core word and address width
    localparam int WORD_SIZE = 32;

    // Line geometry, four words per line
    localparam int LINE_SIZE = 128;
    localparam int WORDS_PER_LINE = LINE_SIZE / WORD_SIZE;
    localparam int LINE_BYTES = LINE_SIZE / 8;
    localparam int OFFSET_SIZE = 4;

    // Direct mapped, one line per set
    localparam int N_LINES = 4;
    localparam int SET_SIZE = 2;
    localparam int TAG_SIZE = WORD_SIZE - SET_SIZE - OFFSET_SIZE;

    // Store buffer depth and pointer widths
    localparam int SB_ENTRIES = 4;
    localparam int SB_PTR_SIZE = $clog2(SB_ENTRIES);
    localparam int SB_COUNT_SIZE = $clog2(SB_ENTRIES + 1);

    // Pin counter must reach SB_ENTRIES
    localparam int PIN_WIDTH = 3;

    // Backing memory, latency of 1 not supported
    localparam int MEM_LATENCY = 4;
    localparam int MEM_LINES = 64;
    localparam int MEM_INDEX_SIZE = $clog2(MEM_LINES);

    // Initial word is its own aligned byte address with top byte forced to A5
    localparam logic [WORD_SIZE-1:0] INIT_MASK = 32'h00ff_fffc;
    localparam logic [WORD_SIZE-1:0] INIT_FILL = 32'ha500_0000;

    typedef enum logic {
        SIZE_BYTE = 1'b0,
        SIZE_WORD = 1'b1
    } access_size_e;

    function automatic logic [WORD_SIZE-1:0] init_word(input logic [WORD_SIZE-1:0] byte_addr);
        return (byte_addr & INIT_MASK) | INIT_FILL;
    endfunction

    function automatic logic [LINE_SIZE-1:0] init_line(input int index);
        logic [LINE_SIZE-1:0] line;
        // Word w of line index sits at byte address index*16 + w*4
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*WORD_SIZE +: WORD_SIZE] = init_word(WORD_SIZE'(index * LINE_BYTES + w * 4));
        end
        return line;
    endfunction

endpackage

`default_nettype wire

/* src/mem_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface mem_if;

    // Line request, one pulse per new miss, line aligned
    logic                             mem_req;
    logic [dcache_pkg::WORD_SIZE-1:0] mem_req_addr;

    // Line response, MEM_LATENCY cycles after its request
    logic                             mem_res;
    logic [dcache_pkg::WORD_SIZE-1:0] mem_res_addr;
    logic [dcache_pkg::LINE_SIZE-1:0] mem_res_data;

    // Dirty victim write-back, applied in the cycle it appears
    logic                             mem_write;
    logic [dcache_pkg::WORD_SIZE-1:0] mem_write_addr;
    logic [dcache_pkg::LINE_SIZE-1:0] mem_write_data;

    modport cache (
        output mem_req, mem_req_addr, mem_write, mem_write_addr, mem_write_data,
        input  mem_res, mem_res_addr, mem_res_data
    );

    modport memory (
        input  mem_req, mem_req_addr, mem_write, mem_write_addr, mem_write_data,
        output mem_res, mem_res_addr, mem_res_data
    );

endinterface

`default_nettype wire

/* src/sb_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface sb_if;

    // Accepted store from the core side of the cache
    logic                             push;
    logic [dcache_pkg::WORD_SIZE-1:0] push_addr;
    logic [dcache_pkg::WORD_SIZE-1:0] push_data;
    dcache_pkg::access_size_e         push_size;

    // Head entry on offer while the buffer holds anything
    logic                             wenable;
    logic [dcache_pkg::WORD_SIZE-1:0] sb_addr;
    logic [dcache_pkg::WORD_SIZE-1:0] sb_value;
    dcache_pkg::access_size_e         sb_size;
    logic                             full;

    // Head written into the cache at this edge
    logic                             store_success;

    modport cache (
        output push, push_addr, push_data, push_size, store_success,
        input  wenable, sb_addr, sb_value, sb_size, full
    );

    modport buffer (
        input  push, push_addr, push_data, push_size, store_success,
        output wenable, sb_addr, sb_value, sb_size, full
    );

endinterface

`default_nettype wire

/* src/cache.sv */
`timescale 1ns/1ns
`default_nettype none

module cache (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              valid,
    input  wire [dcache_pkg::WORD_SIZE-1:0]  addr,
    input  wire                              store,
    input  wire dcache_pkg::access_size_e    size,
    input  wire [dcache_pkg::WORD_SIZE-1:0]  store_data,
    output logic                             hit,
    output logic                             stall,
    output logic [dcache_pkg::WORD_SIZE-1:0] read_data,
    mem_if.cache                             mem,
    sb_if.cache                              sb
);

    // Resident lines
    logic [dcache_pkg::TAG_SIZE-1:0]  tags [dcache_pkg::N_LINES];
    logic [dcache_pkg::LINE_SIZE-1:0] data [dcache_pkg::N_LINES];
    logic [dcache_pkg::N_LINES-1:0]   line_valid;
    logic [dcache_pkg::N_LINES-1:0]   dirty;
    // Stores waiting in the buffer for each resident line
    logic [dcache_pkg::PIN_WIDTH-1:0] pins [dcache_pkg::N_LINES];

    // One outstanding miss per set
    logic [dcache_pkg::N_LINES-1:0]   pend_present;
    logic [dcache_pkg::TAG_SIZE-1:0]  pend_tag [dcache_pkg::N_LINES];
    logic [dcache_pkg::PIN_WIDTH-1:0] pend_pin [dcache_pkg::N_LINES];

    // Per-set pin adjustments this cycle
    logic [dcache_pkg::PIN_WIDTH-1:0] pin_inc  [dcache_pkg::N_LINES];
    logic [dcache_pkg::PIN_WIDTH-1:0] pin_dec  [dcache_pkg::N_LINES];
    logic [dcache_pkg::PIN_WIDTH-1:0] pend_inc [dcache_pkg::N_LINES];

    // Address split for core, store buffer head and memory response
    logic [dcache_pkg::OFFSET_SIZE-1:0] offset;
    logic [dcache_pkg::SET_SIZE-1:0]    set_idx;
    logic [dcache_pkg::TAG_SIZE-1:0]    tag;
    logic [dcache_pkg::OFFSET_SIZE-1:0] sb_offset;
    logic [dcache_pkg::SET_SIZE-1:0]    sb_set;
    logic [dcache_pkg::TAG_SIZE-1:0]    sb_tag;
    logic [dcache_pkg::SET_SIZE-1:0]    res_set;
    logic [dcache_pkg::TAG_SIZE-1:0]    res_tag;

    logic line_hit;
    logic set_free;
    logic pend_match;
    logic store_ok;
    logic store_accept;
    logic install;

    logic [dcache_pkg::LINE_SIZE-1:0] line_rd;
    logic [7:0]                       rd_byte;
    logic [dcache_pkg::WORD_SIZE-1:0] rd_word;
    logic [dcache_pkg::LINE_SIZE-1:0] merged;

    assign offset  = addr[dcache_pkg::OFFSET_SIZE-1:0];
    assign set_idx = addr[dcache_pkg::OFFSET_SIZE +: dcache_pkg::SET_SIZE];
    assign tag     = addr[dcache_pkg::WORD_SIZE-1 -: dcache_pkg::TAG_SIZE];

    assign sb_offset = sb.sb_addr[dcache_pkg::OFFSET_SIZE-1:0];
    assign sb_set    = sb.sb_addr[dcache_pkg::OFFSET_SIZE +: dcache_pkg::SET_SIZE];
    assign sb_tag    = sb.sb_addr[dcache_pkg::WORD_SIZE-1 -: dcache_pkg::TAG_SIZE];

    assign res_set = mem.mem_res_addr[dcache_pkg::OFFSET_SIZE +: dcache_pkg::SET_SIZE];
    assign res_tag = mem.mem_res_addr[dcache_pkg::WORD_SIZE-1 -: dcache_pkg::TAG_SIZE];

    // Lookup, same cycle as valid
    assign line_hit   = line_valid[set_idx] && (tags[set_idx] == tag);
    // Set may be refilled only when nothing is pending and nothing is pinned
    assign set_free   = !pend_present[set_idx] && (pins[set_idx] == '0);
    assign pend_match = pend_present[set_idx] && (pend_tag[set_idx] == tag);

    // Store goes ahead on a hit with no refill under way, or rides a request for its tag
    assign store_ok = (line_hit && !pend_present[set_idx]) || pend_match ||
                      (!line_hit && set_free);

    assign stall        = valid && (sb.full || (store ? !store_ok : !line_hit));
    assign hit          = valid && line_hit && !stall;
    assign store_accept = valid && store && !stall;

    // Miss request, dropped next cycle once pend_present is set
    assign mem.mem_req      = valid && !line_hit && set_free;
    assign mem.mem_req_addr = {tag, set_idx, {dcache_pkg::OFFSET_SIZE{1'b0}}};

    // Accepted stores go straight into the buffer
    assign sb.push      = store_accept;
    assign sb.push_addr = addr;
    assign sb.push_data = store_data;
    assign sb.push_size = size;

    // Head commits once its line is resident
    assign sb.store_success = sb.wenable && line_valid[sb_set] && (tags[sb_set] == sb_tag);

    // Victim leaves in the cycle its replacement arrives
    assign install            = mem.mem_res && pend_present[res_set];
    assign mem.mem_write      = install && line_valid[res_set] && dirty[res_set];
    assign mem.mem_write_addr = {tags[res_set], res_set, {dcache_pkg::OFFSET_SIZE{1'b0}}};
    assign mem.mem_write_data = data[res_set];

    // Load extraction, byte is sign extended
    assign line_rd = data[set_idx];
    assign rd_byte = line_rd[{offset, 3'b000} +: 8];
    assign rd_word = line_rd[{offset[dcache_pkg::OFFSET_SIZE-1:2], 5'b00000} +: dcache_pkg::WORD_SIZE];
    assign read_data = (size == dcache_pkg::SIZE_BYTE) ?
                       {{(dcache_pkg::WORD_SIZE-8){rd_byte[7]}}, rd_byte} : rd_word;

    // Merge the head store into its line
    always_comb begin
        merged = data[sb_set];
        if (sb.sb_size == dcache_pkg::SIZE_BYTE) begin
            merged[{sb_offset, 3'b000} +: 8] = sb.sb_value[7:0];
        end else begin
            merged[{sb_offset[dcache_pkg::OFFSET_SIZE-1:2], 5'b00000} +: dcache_pkg::WORD_SIZE] =
                sb.sb_value;
        end
    end

    always_comb begin
        for (int s = 0; s < dcache_pkg::N_LINES; s++) begin
            pin_inc[s]  = '0;
            pin_dec[s]  = '0;
            pend_inc[s] = '0;
            pin_inc[s][0]  = store_accept && line_hit && (set_idx == s);
            pin_dec[s][0]  = sb.store_success && (sb_set == s);
            // Accepted store on a miss pins the pending or newly requested line
            pend_inc[s][0] = store_accept && !line_hit && (set_idx == s);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid   <= '0;
            dirty        <= '0;
            pend_present <= '0;
            for (int s = 0; s < dcache_pkg::N_LINES; s++) begin
                tags[s]     <= '0;
                pins[s]     <= '0;
                pend_tag[s] <= '0;
                pend_pin[s] <= '0;
            end
        end else begin
            for (int s = 0; s < dcache_pkg::N_LINES; s++) begin
                if (install && (res_set == s)) begin
                    // New line is clean and takes over the pending pins
                    line_valid[s]   <= 1'b1;
                    tags[s]         <= res_tag;
                    dirty[s]        <= 1'b0;
                    pins[s]         <= pend_pin[s] + pend_inc[s];
                    pend_present[s] <= 1'b0;
                    pend_pin[s]     <= '0;
                end else begin
                    pins[s] <= pins[s] + pin_inc[s] - pin_dec[s];
                    if (pin_dec[s][0]) begin
                        dirty[s] <= 1'b1;
                    end
                    if (mem.mem_req && (set_idx == s)) begin
                        pend_present[s] <= 1'b1;
                        pend_tag[s]     <= tag;
                        pend_pin[s]     <= pend_inc[s];
                    end else begin
                        pend_pin[s] <= pend_pin[s] + pend_inc[s];
                    end
                end
            end
        end
    end

    // Line data, the two writes never target the same set
    always_ff @(posedge clk) begin
        if (sb.store_success) begin
            data[sb_set] <= merged;
        end
        if (install) begin
            data[res_set] <= mem.mem_res_data;
        end
    end

endmodule

`default_nettype wire

/* src/store_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module store_buffer (
    input  wire  clk,
    input  wire  rst,
    sb_if.buffer sb,
    output logic sb_empty
);

    // Circular entry payload
    logic [dcache_pkg::WORD_SIZE-1:0] addr_q  [dcache_pkg::SB_ENTRIES];
    logic [dcache_pkg::WORD_SIZE-1:0] value_q [dcache_pkg::SB_ENTRIES];
    dcache_pkg::access_size_e         size_q  [dcache_pkg::SB_ENTRIES];

    // Head points at the oldest store and tail at the next free slot
    logic [dcache_pkg::SB_PTR_SIZE-1:0]   head;
    logic [dcache_pkg::SB_PTR_SIZE-1:0]   tail;
    logic [dcache_pkg::SB_COUNT_SIZE-1:0] count;

    logic do_push;
    logic do_pop;

    assign sb_empty = (count == '0);
    assign sb.full  = (count == dcache_pkg::SB_ENTRIES);

    // Push lands only in a free slot
    assign do_push = sb.push && !sb.full;
    // Pop on a successful cache write of the head
    assign do_pop  = sb.store_success && !sb_empty;

    // Head offered continuously
    assign sb.wenable  = !sb_empty;
    assign sb.sb_addr  = addr_q[head];
    assign sb.sb_value = value_q[head];
    assign sb.sb_size  = size_q[head];

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_q[tail]  <= sb.push_addr;
            value_q[tail] <= sb.push_data;
            size_q[tail]  <= sb.push_size;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Pointers wrap since the depth is a power of two
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/line_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module line_memory (
    input  wire   clk,
    input  wire   rst,
    mem_if.memory mem
);

    logic [dcache_pkg::LINE_SIZE-1:0] lines [dcache_pkg::MEM_LINES];

    // Response pipeline, last stage drives the response
    logic [dcache_pkg::MEM_LATENCY-1:0] pipe_valid;
    logic [dcache_pkg::WORD_SIZE-1:0]   pipe_addr [dcache_pkg::MEM_LATENCY];
    logic [dcache_pkg::LINE_SIZE-1:0]   pipe_data [dcache_pkg::MEM_LATENCY];

    // Higher address bits alias
    logic [dcache_pkg::MEM_INDEX_SIZE-1:0] req_index;
    logic [dcache_pkg::MEM_INDEX_SIZE-1:0] wr_index;
    logic [dcache_pkg::LINE_SIZE-1:0]      req_line;

    assign req_index = mem.mem_req_addr[dcache_pkg::OFFSET_SIZE +: dcache_pkg::MEM_INDEX_SIZE];
    assign wr_index  = mem.mem_write_addr[dcache_pkg::OFFSET_SIZE +: dcache_pkg::MEM_INDEX_SIZE];

    // Write-back in the request cycle is seen by the request
    assign req_line = (mem.mem_write && (wr_index == req_index)) ?
                      mem.mem_write_data : lines[req_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dcache_pkg::MEM_LINES; i++) begin
                lines[i] <= dcache_pkg::init_line(i);
            end
        end else if (mem.mem_write) begin
            lines[wr_index] <= mem.mem_write_data;
        end
    end

    // One request per cycle enters stage 0
    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[dcache_pkg::MEM_LATENCY-2:0], mem.mem_req};
        end
    end

    always_ff @(posedge clk) begin
        pipe_addr[0] <= mem.mem_req_addr;
        pipe_data[0] <= req_line;
        for (int k = 1; k < dcache_pkg::MEM_LATENCY; k++) begin
            pipe_addr[k] <= pipe_addr[k-1];
            pipe_data[k] <= pipe_data[k-1];
        end
    end

    assign mem.mem_res      = pipe_valid[dcache_pkg::MEM_LATENCY-1];
    assign mem.mem_res_addr = pipe_addr[dcache_pkg::MEM_LATENCY-1];
    assign mem.mem_res_data = pipe_data[dcache_pkg::MEM_LATENCY-1];

endmodule

`default_nettype wire

/* src/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             valid,
    input  wire [dcache_pkg::WORD_SIZE-1:0] addr,
    input  wire                             store,
    input  wire dcache_pkg::access_size_e   size,
    input  wire [dcache_pkg::WORD_SIZE-1:0] store_data,
    output wire                             hit,
    output wire                             stall,
    output wire [dcache_pkg::WORD_SIZE-1:0] read_data,
    output wire                             sb_empty
);

    // Cache to memory
    mem_if mem_bus ();
    // Cache to store buffer
    sb_if sb_bus ();

    cache u_cache (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .addr       (addr),
        .store      (store),
        .size       (size),
        .store_data (store_data),
        .hit        (hit),
        .stall      (stall),
        .read_data  (read_data),
        .mem        (mem_bus.cache),
        .sb         (sb_bus.cache)
    );

    store_buffer u_store_buffer (
        .clk      (clk),
        .rst      (rst),
        .sb       (sb_bus.buffer),
        .sb_empty (sb_empty)
    );

    line_memory u_line_memory (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus.memory)
    );

endmodule

`default_nettype wire

/* verif/dcache_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_properties (
    input wire clk,
    input wire rst,
    input wire valid,
    input wire store,
    input wire hit,
    input wire stall,
    input wire mem_req,
    input wire mem_res,
    input wire mem_write,
    input wire full,
    input wire wenable,
    input wire store_success
);

    // A held load hits or stalls and a store never does both
    hit_or_stall: assert property (@(posedge clk) disable iff (rst)
        valid |-> (store ? !(hit && stall) : (hit != stall)))
        else $error("hit and stall disagree on a held access");

    // Fixed latency line memory answers every request once
    req_to_res: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> ##(dcache_pkg::MEM_LATENCY) mem_res)
        else $error("mem_req not answered after the memory latency");

    // wenable mirrors a non-empty buffer so full needs it high
    full_not_empty: assert property (@(posedge clk) disable iff (rst)
        full |-> wenable)
        else $error("store buffer full and empty at once");

    drain_has_head: assert property (@(posedge clk) disable iff (rst)
        store_success |-> wenable)
        else $error("store_success without wenable");

    // Nothing moves right after reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !mem_req && !mem_write && !wenable)
        else $error("bus activity in the cycle after reset");

endmodule

bind cache dcache_properties props (
    .clk           (clk),
    .rst           (rst),
    .valid         (valid),
    .store         (store),
    .hit           (hit),
    .stall         (stall),
    .mem_req       (mem.mem_req),
    .mem_res       (mem.mem_res),
    .mem_write     (mem.mem_write),
    .full          (sb.full),
    .wenable       (sb.wenable),
    .store_success (sb.store_success)
);

`default_nettype wire

/* verif/dcache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

    localparam int RESET_CYCLES = 16;
    localparam int N_DIRECTED = 12;
    localparam int N_RANDOM = 200;
    // Budget per operation covers a refill, a full drain and some slack
    localparam int OP_CYCLES = dcache_pkg::MEM_LATENCY + 2 * dcache_pkg::SB_ENTRIES + 4;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * OP_CYCLES + RESET_CYCLES + 8;

    logic clk = 1'b0;
    logic rst;
    logic valid;
    logic [31:0] addr;
    logic store;
    dcache_pkg::access_size_e size;
    logic [31:0] store_data;
    wire hit;
    wire stall;
    wire [31:0] read_data;
    wire sb_empty;

    // Reference memory, word index over the low 1 KB
    logic [31:0] model [256];
    logic verdict_done = 1'b0;
    logic [31:0] rnd;
    logic [31:0] a;
    dcache_pkg::access_size_e sz;
    int waited;

    dcache_top dut (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .addr       (addr),
        .store      (store),
        .size       (size),
        .store_data (store_data),
        .hit        (hit),
        .stall      (stall),
        .read_data  (read_data),
        .sb_empty   (sb_empty)
    );

    always #5 clk = ~clk;

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        verdict_done = 1'b1;
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Byte loads sign extend the addressed lane
    function automatic logic [31:0] expected_load(input logic [31:0] ad,
                                                  input dcache_pkg::access_size_e sz_in);
        logic [31:0] w;
        logic [7:0] b;
        w = model[ad[9:2]];
        b = w[{ad[1:0], 3'b000} +: 8];
        if (sz_in == dcache_pkg::SIZE_BYTE) begin
            return {{24{b[7]}}, b};
        end
        return w;
    endfunction

    task automatic load(input logic [31:0] ad, input dcache_pkg::access_size_e sz_in,
                        output int cycles);
        logic [31:0] expected;
        expected = expected_load(ad, sz_in);
        valid = 1'b1;
        store = 1'b0;
        addr = ad;
        size = sz_in;
        cycles = 0;
        @(negedge clk);
        while (!hit) begin
            cycles++;
            @(negedge clk);
        end
        assert (read_data == expected)
            else stop_on_failure($sformatf("FAILED read_data at %h: got %h expected %h",
                                           ad, read_data, expected));
        @(posedge clk);
        #1 valid = 1'b0;
    endtask

    task automatic store_op(input logic [31:0] ad, input dcache_pkg::access_size_e sz_in,
                            input logic [31:0] d);
        valid = 1'b1;
        store = 1'b1;
        addr = ad;
        size = sz_in;
        store_data = d;
        @(negedge clk);
        while (stall) @(negedge clk);
        @(posedge clk);
        #1;
        // The store entered the buffer at that edge
        assert (!sb_empty)
            else stop_on_failure($sformatf("FAILED sb_empty at %h: got %h expected %h",
                                           ad, sb_empty, 1'b0));
        // Model follows the accepted store at once
        if (sz_in == dcache_pkg::SIZE_BYTE) begin
            model[ad[9:2]][{ad[1:0], 3'b000} +: 8] = d[7:0];
        end else begin
            model[ad[9:2]] = d;
        end
        valid = 1'b0;
        store = 1'b0;
    endtask

    task automatic wait_sb_empty();
        while (!sb_empty) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_failure("timeout: the tests did not finish within the cycle budget");
    end

    initial begin
        // Each word starts as its own byte address with A5 on top
        for (int w = 0; w < 256; w++) begin
            model[w] = 32'ha500_0000 | (32'(w) << 2);
        end
        rst = 1'b1;
        valid = 1'b0;
        addr = '0;
        store = 1'b0;
        size = dcache_pkg::SIZE_WORD;
        store_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1;
        assert (sb_empty)
            else stop_on_failure($sformatf("FAILED sb_empty after reset: got %h expected %h",
                                           sb_empty, 1'b1));

        // Cold miss followed by a hit in the same line
        load(32'h0000_0124, dcache_pkg::SIZE_WORD, waited);
        assert (waited > 0) else stop_on_failure("first load after reset did not stall");
        load(32'h0000_0128, dcache_pkg::SIZE_WORD, waited);
        assert (waited == 0) else stop_on_failure("load to a resident line did not hit");
        // Lane 3 holds A5 and extends with ones while lane 1 stays positive
        load(32'h0000_012b, dcache_pkg::SIZE_BYTE, waited);
        load(32'h0000_0129, dcache_pkg::SIZE_BYTE, waited);

        // Byte and word merge
        store_op(32'h0000_0131, dcache_pkg::SIZE_BYTE, 32'h0000_005c);
        store_op(32'h0000_0134, dcache_pkg::SIZE_WORD, 32'hdead_beef);
        wait_sb_empty();
        load(32'h0000_0130, dcache_pkg::SIZE_WORD, waited);
        load(32'h0000_0131, dcache_pkg::SIZE_BYTE, waited);
        load(32'h0000_0134, dcache_pkg::SIZE_WORD, waited);

        // 0x040 and 0x0c0 share set 0 so loading 0x0c0 evicts the dirty line
        store_op(32'h0000_0040, dcache_pkg::SIZE_WORD, 32'h1234_5678);
        wait_sb_empty();
        load(32'h0000_00c0, dcache_pkg::SIZE_WORD, waited);
        load(32'h0000_0040, dcache_pkg::SIZE_WORD, waited);

        // Random mix over 16 lines with four tags per set
        rnd = 32'h1d6f;
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = next_random(rnd);
            sz = rnd[5] ? dcache_pkg::SIZE_WORD : dcache_pkg::SIZE_BYTE;
            if (rnd[5]) begin
                a = {24'b0, rnd[3:0], rnd[7:6], 2'b00};
            end else begin
                a = {24'b0, rnd[3:0], rnd[11:8]};
            end
            if (rnd[4]) begin
                rnd = next_random(rnd);
                store_op(a, sz, rnd);
            end else begin
                wait_sb_empty();
                load(a, sz, waited);
            end
        end

        $display("ALL TESTS PASSED");
        verdict_done = 1'b1;
        $finish;
    end

    // Run cut short by a bound assertion
    final begin
        if (!verdict_done) begin
            $display("SOME TESTS FAILED");
        end
    end

endmodule

`default_nettype wire

/* src.f */
src/dcache_pkg.sv
src/mem_if.sv
src/sb_if.sv
src/cache.sv
src/store_buffer.sv
src/line_memory.sv
src/dcache_top.sv
verif/dcache_properties.sv
verif/dcache_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f src.f -o dcache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
